/* include/csr_unit_defines.svh */
// Width, reset values and write masks of the CSR unit
// Included by the packages and modules that size or initialize registers

`ifndef CSR_UNIT_DEFINES_SVH
`define CSR_UNIT_DEFINES_SVH

// Data path width of every register
`define CSR_WIDTH 32

// CTRL: bit 0 enables the cycle counter, bit 1 is spare
`define CSR_CTRL_RESET 32'h0000_0000
`define CSR_CTRL_MASK 32'h0000_0003

// SCRATCH is fully writable
`define CSR_SCRATCH_RESET 32'h0000_0000
`define CSR_SCRATCH_MASK 32'hFFFF_FFFF

// ID is a constant, no bit is writable
`define CSR_ID_VALUE 32'h5343_0001
`define CSR_ID_MASK 32'h0000_0000

`endif

/* rtl/csr_map_pkg.sv */
// Register map of the CSR unit: address codes and integrity flags
// Shared by the bus package, the register file and the testbench

package csr_map_pkg;

    // One code per register, all four codes are in use
    typedef enum logic [1:0] {
        ADDR_CTRL    = 2'd0,
        ADDR_SCRATCH = 2'd1,
        ADDR_ID      = 2'd2,
        ADDR_CYCLE   = 2'd3
    } csr_addr_e;

    // Shadow mismatch per hardened register
    typedef struct packed {
        logic ctrl;
        logic scratch;
        logic cycle;
    } csr_integrity_t;

endpackage

/* rtl/csr_bus_pkg.sv */
// Request and response types of the CSR access channel
// Both channels use a valid/ready handshake around these structs

`include "csr_unit_defines.svh"

package csr_bus_pkg;

    // Every operation returns the old value
    typedef enum logic [1:0] {
        OP_READ  = 2'd0,
        OP_WRITE = 2'd1,
        OP_SET   = 2'd2,
        OP_CLEAR = 2'd3
    } csr_op_e;

    typedef struct packed {
        csr_op_e                op;
        csr_map_pkg::csr_addr_e addr;
        logic [`CSR_WIDTH-1:0]  wdata;
    } csr_req_t;

    typedef struct packed {
        logic [`CSR_WIDTH-1:0] rdata;
        logic                  err;
    } csr_rsp_t;

endpackage

/* rtl/csr_reg.sv */
// Single CSR with write mask, reset value and optional inverted shadow copy
// rd_error_o flags a disagreement between the register and its shadow

`timescale 1ns/10ps

module csr_reg #(
    parameter int unsigned      WIDTH      = 32,
    parameter bit               SHADOW     = 1'b0,
    parameter logic [WIDTH-1:0] RESETVALUE = '0,
    parameter logic [WIDTH-1:0] MASK       = '1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en_i,
    input  logic [WIDTH-1:0] wr_data_i,
    output logic [WIDTH-1:0] rd_data_o,
    output logic             rd_error_o
);

    logic [WIDTH-1:0] data_q;

    assign rd_data_o = data_q;

    for (genvar i = 0; i < WIDTH; i++) begin : gen_bit
        if (MASK[i]) begin : gen_live
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    data_q[i] <= RESETVALUE[i];
                end else if (wr_en_i) begin
                    data_q[i] <= wr_data_i[i];
                end
            end
        end else begin : gen_tied
            // Read-only bit, keeps its reset value
            assign data_q[i] = RESETVALUE[i];
        end
    end

    if (SHADOW) begin : gen_shadow
        logic [WIDTH-1:0] shadow_q;

        for (genvar i = 0; i < WIDTH; i++) begin : gen_bit
            if (MASK[i]) begin : gen_live
                // Twin holds the complement, written together with the data bit
                always_ff @(posedge clk or negedge rst_n) begin
                    if (!rst_n) begin
                        shadow_q[i] <= ~RESETVALUE[i];
                    end else if (wr_en_i) begin
                        shadow_q[i] <= ~wr_data_i[i];
                    end
                end
            end else begin : gen_tied
                assign shadow_q[i] = ~RESETVALUE[i];
            end
        end

        assign rd_error_o = (data_q != ~shadow_q);
    end else begin : gen_plain
        assign rd_error_o = 1'b0;
    end

endmodule

/* rtl/csr_cycle_counter.sv */
// Loadable cycle counter with an inverted shadow count
// A load wins over counting; mismatch_o is high while the pair disagrees

`timescale 1ns/10ps
`include "csr_unit_defines.svh"

module csr_cycle_counter (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  count_en_i,
    input  logic                  load_i,
    input  logic [`CSR_WIDTH-1:0] load_data_i,
    output logic [`CSR_WIDTH-1:0] count_o,
    output logic                  mismatch_o
);

    logic [`CSR_WIDTH-1:0] count_q;
    logic [`CSR_WIDTH-1:0] shadow_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q  <= '0;
            shadow_q <= '1;
        end else if (load_i) begin
            count_q  <= load_data_i;
            shadow_q <= ~load_data_i;
        end else if (count_en_i) begin
            count_q  <= count_q + 1'b1;
            // ~(x + 1) equals ~x - 1, so the shadow has its own adder
            shadow_q <= shadow_q - 1'b1;
        end
    end

    assign count_o    = count_q;
    assign mismatch_o = (count_q != ~shadow_q);

endmodule

/* rtl/csr_access_fsm.sv */
// Sequences one CSR operation at a time: accept, read-modify-write, respond
// The response is registered in EXEC and held in RESP until it is consumed

`timescale 1ns/10ps
`include "csr_unit_defines.svh"

module csr_access_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid_i,
    output logic                   req_ready_o,
    input  csr_bus_pkg::csr_req_t  req_i,
    output logic                   rsp_valid_o,
    input  logic                   rsp_ready_i,
    output csr_bus_pkg::csr_rsp_t  rsp_o,
    output csr_map_pkg::csr_addr_e reg_addr_o,
    output logic                   reg_wr_en_o,
    output logic [`CSR_WIDTH-1:0]  reg_wr_data_o,
    input  logic [`CSR_WIDTH-1:0]  reg_rd_data_i,
    input  logic                   reg_addr_err_i
);

    typedef enum logic [1:0] {
        IDLE,
        EXEC,
        RESP
    } state_e;

    state_e                state_q;
    state_e                state_d;
    csr_bus_pkg::csr_req_t req_q;
    csr_bus_pkg::csr_rsp_t rsp_q;
    logic                  accept;
    logic                  consume;

    assign req_ready_o = (state_q == IDLE);
    assign rsp_valid_o = (state_q == RESP);
    assign accept      = req_valid_i && req_ready_o;
    assign consume     = rsp_valid_o && rsp_ready_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: if (accept) state_d = EXEC;
            EXEC: state_d = RESP;
            RESP: if (consume) state_d = IDLE;
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request and response payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req_i;
        end
        if (state_q == EXEC) begin
            rsp_q.rdata <= reg_rd_data_i;
            rsp_q.err   <= reg_addr_err_i;
        end
    end

    // New value from the old one, resolved within the EXEC cycle
    always_comb begin
        case (req_q.op)
            csr_bus_pkg::OP_WRITE: reg_wr_data_o = req_q.wdata;
            csr_bus_pkg::OP_SET:   reg_wr_data_o = reg_rd_data_i | req_q.wdata;
            csr_bus_pkg::OP_CLEAR: reg_wr_data_o = reg_rd_data_i & ~req_q.wdata;
            default:               reg_wr_data_o = reg_rd_data_i;
        endcase
    end

    assign reg_addr_o  = req_q.addr;
    assign reg_wr_en_o = (state_q == EXEC) && (req_q.op != csr_bus_pkg::OP_READ) &&
                         !reg_addr_err_i;
    assign rsp_o       = rsp_q;

endmodule

/* rtl/csr_file.sv */
// Register file of the CSR unit: decode, register instances and read mux
// Shadow mismatches are collected and raised as a registered alert

`timescale 1ns/10ps
`include "csr_unit_defines.svh"

module csr_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  csr_map_pkg::csr_addr_e addr_i,
    input  logic                   wr_en_i,
    input  logic [`CSR_WIDTH-1:0]  wr_data_i,
    output logic [`CSR_WIDTH-1:0]  rd_data_o,
    output logic                   addr_err_o,
    output logic                   alert_o
);

    logic [`CSR_WIDTH-1:0]       ctrl_q;
    logic [`CSR_WIDTH-1:0]       scratch_q;
    logic [`CSR_WIDTH-1:0]       id_q;
    logic [`CSR_WIDTH-1:0]       cycle_q;
    logic                        wr_ctrl;
    logic                        wr_scratch;
    logic                        wr_cycle;
    csr_map_pkg::csr_integrity_t integrity;
    logic                        alert_q;

    // No write enable for ID, writes to it are dropped
    assign wr_ctrl    = wr_en_i && (addr_i == csr_map_pkg::ADDR_CTRL);
    assign wr_scratch = wr_en_i && (addr_i == csr_map_pkg::ADDR_SCRATCH);
    assign wr_cycle   = wr_en_i && (addr_i == csr_map_pkg::ADDR_CYCLE);

    csr_reg #(
        .WIDTH(`CSR_WIDTH), .SHADOW(1'b1), .RESETVALUE(`CSR_CTRL_RESET), .MASK(`CSR_CTRL_MASK)
    ) ctrl_reg (
        .clk(clk), .rst_n(rst_n), .wr_en_i(wr_ctrl), .wr_data_i(wr_data_i),
        .rd_data_o(ctrl_q), .rd_error_o(integrity.ctrl)
    );

    csr_reg #(
        .WIDTH(`CSR_WIDTH), .SHADOW(1'b1), .RESETVALUE(`CSR_SCRATCH_RESET),
        .MASK(`CSR_SCRATCH_MASK)
    ) scratch_reg (
        .clk(clk), .rst_n(rst_n), .wr_en_i(wr_scratch), .wr_data_i(wr_data_i),
        .rd_data_o(scratch_q), .rd_error_o(integrity.scratch)
    );

    // Fully masked, so it has no flops and no shadow
    csr_reg #(
        .WIDTH(`CSR_WIDTH), .SHADOW(1'b0), .RESETVALUE(`CSR_ID_VALUE), .MASK(`CSR_ID_MASK)
    ) id_reg (
        .clk(clk), .rst_n(rst_n), .wr_en_i(1'b0), .wr_data_i(wr_data_i),
        .rd_data_o(id_q), .rd_error_o()
    );

    csr_cycle_counter cycle_cnt (
        .clk(clk), .rst_n(rst_n), .count_en_i(ctrl_q[0]), .load_i(wr_cycle),
        .load_data_i(wr_data_i), .count_o(cycle_q), .mismatch_o(integrity.cycle)
    );

    // Old value at the addressed register
    always_comb begin
        addr_err_o = 1'b0;
        case (addr_i)
            csr_map_pkg::ADDR_CTRL:    rd_data_o = ctrl_q;
            csr_map_pkg::ADDR_SCRATCH: rd_data_o = scratch_q;
            csr_map_pkg::ADDR_ID:      rd_data_o = id_q;
            csr_map_pkg::ADDR_CYCLE:   rd_data_o = cycle_q;
            default: begin
                rd_data_o  = '0;
                addr_err_o = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alert_q <= 1'b0;
        end else begin
            alert_q <= |integrity;
        end
    end

    assign alert_o = alert_q;

endmodule

/* rtl/csr_unit_top.sv */
// Top level of the CSR unit with request/response channels and integrity alert
// Connects the access FSM to the register file

`timescale 1ns/10ps
`include "csr_unit_defines.svh"

module csr_unit_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid_i,
    output logic                  req_ready_o,
    input  csr_bus_pkg::csr_req_t req_i,
    output logic                  rsp_valid_o,
    input  logic                  rsp_ready_i,
    output csr_bus_pkg::csr_rsp_t rsp_o,
    output logic                  alert_o
);

    csr_map_pkg::csr_addr_e reg_addr;
    logic                   reg_wr_en;
    logic [`CSR_WIDTH-1:0]  reg_wr_data;
    logic [`CSR_WIDTH-1:0]  reg_rd_data;
    logic                   reg_addr_err;

    csr_access_fsm fsm0 (
        .clk(clk), .rst_n(rst_n),
        .req_valid_i(req_valid_i), .req_ready_o(req_ready_o), .req_i(req_i),
        .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_o(rsp_o),
        .reg_addr_o(reg_addr), .reg_wr_en_o(reg_wr_en), .reg_wr_data_o(reg_wr_data),
        .reg_rd_data_i(reg_rd_data), .reg_addr_err_i(reg_addr_err)
    );

    csr_file file0 (
        .clk(clk), .rst_n(rst_n), .addr_i(reg_addr), .wr_en_i(reg_wr_en),
        .wr_data_i(reg_wr_data), .rd_data_o(reg_rd_data), .addr_err_o(reg_addr_err),
        .alert_o(alert_o)
    );

endmodule

/* tests/csr_unit_assertions.sv */
// Concurrent checks on the CSR unit ports, bound into the top level
// Failures are reported by the simulator's assertion messages

`timescale 1ns/10ps

module csr_unit_assertions (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  req_valid_i,
    input logic                  req_ready_o,
    input logic                  rsp_valid_o,
    input logic                  rsp_ready_i,
    input csr_bus_pkg::csr_rsp_t rsp_o,
    input logic                  alert_o
);

    // A held response keeps both its valid and its payload
    rsp_held_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)))
        else $error("response changed while it was held");

    ready_valid_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(req_ready_o && rsp_valid_o))
        else $error("request ready while a response is pending");

    alert_low: assert property (@(posedge clk) disable iff (!rst_n) !alert_o)
        else $error("integrity alert raised");

    rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (req_valid_i && req_ready_o) |-> ##2 $rose(rsp_valid_o))
        else $error("response did not rise two cycles after acceptance");

endmodule

/* tests/csr_unit_checker.sv */
// Response checker of the CSR unit testbench
// The testbench queues an expectation per accepted request; responses are compared in order

`timescale 1ns/10ps
`include "csr_unit_defines.svh"

module csr_unit_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid_i,
    input  logic                  req_ready_i,
    input  logic                  rsp_valid_i,
    input  logic                  rsp_ready_i,
    input  csr_bus_pkg::csr_rsp_t rsp_i,
    input  logic                  alert_i,
    output int                    mismatch_count_o,
    output int                    unexpected_count_o,
    output int                    protocol_count_o,
    output int                    pending_count_o
);

    // Kind 0 is an exact value, 1 any value, 2 above the previous response
    string                 name_q[$];
    logic [`CSR_WIDTH-1:0] rdata_q[$];
    logic                  err_q[$];
    int                    kind_q[$];
    logic [`CSR_WIDTH-1:0] last_rdata = '0;
    logic                  held       = 1'b0;
    csr_bus_pkg::csr_rsp_t held_rsp;
    logic                  accept_d1  = 1'b0;
    logic                  accept_d2  = 1'b0;
    logic                  valid_d1   = 1'b0;
    int                    mismatches = 0;
    int                    unexpected = 0;
    int                    protocol   = 0;
    int                    pending    = 0;

    assign mismatch_count_o   = mismatches;
    assign unexpected_count_o = unexpected;
    assign protocol_count_o   = protocol;
    assign pending_count_o    = pending;

    task automatic queue_response(input string name, input logic [`CSR_WIDTH-1:0] rdata,
                                  input logic err, input int kind);
        name_q.push_back(name);
        rdata_q.push_back(rdata);
        err_q.push_back(err);
        kind_q.push_back(kind);
        pending++;
    endtask

    task automatic expect_exact(input string name, input logic [`CSR_WIDTH-1:0] rdata,
                                input logic err);
        queue_response(name, rdata, err, 0);
    endtask

    task automatic expect_any(input string name, input logic err);
        queue_response(name, '0, err, 1);
    endtask

    task automatic expect_rise(input string name, input logic err);
        queue_response(name, '0, err, 2);
    endtask

    task automatic report_protocol(input string msg);
        protocol++;
        $display("ERROR: %s at %0t", msg, $time);
    endtask

    task automatic compare_response();
        string                 name;
        logic [`CSR_WIDTH-1:0] exp_rdata;
        logic                  exp_err;
        int                    kind;
        if (kind_q.size() == 0) begin
            unexpected++;
            $display("ERROR: response 0x%08h arrived with no expected entry", rsp_i.rdata);
        end else begin
            name      = name_q.pop_front();
            exp_rdata = rdata_q.pop_front();
            exp_err   = err_q.pop_front();
            kind      = kind_q.pop_front();
            pending--;
            if (rsp_i.err !== exp_err) begin
                mismatches++;
                $display("MISMATCH %s: err expected %0b, actual %0b", name, exp_err, rsp_i.err);
            end
            if (kind == 0 && rsp_i.rdata !== exp_rdata) begin
                mismatches++;
                $display("MISMATCH %s: expected 0x%08h, actual 0x%08h",
                         name, exp_rdata, rsp_i.rdata);
            end else if (kind == 2 && !(rsp_i.rdata > last_rdata)) begin
                mismatches++;
                $display("MISMATCH %s: expected above 0x%08h, actual 0x%08h",
                         name, last_rdata, rsp_i.rdata);
            end
        end
        last_rdata = rsp_i.rdata;
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (alert_i) begin
                report_protocol("integrity alert is high");
            end
            if (req_ready_i && rsp_valid_i) begin
                report_protocol("request channel ready while a response is pending");
            end
            // Response valid rises on the second edge after acceptance
            if (accept_d2 && !(rsp_valid_i && !valid_d1)) begin
                report_protocol("response did not rise two cycles after acceptance");
            end
            if (held && !rsp_valid_i) begin
                report_protocol("response withdrawn before it was consumed");
            end else if (held && rsp_i !== held_rsp) begin
                report_protocol("held response changed its value");
            end
            if (rsp_valid_i && rsp_ready_i) begin
                compare_response();
            end
            held      = rsp_valid_i && !rsp_ready_i;
            held_rsp  = rsp_i;
            accept_d2 = accept_d1;
            accept_d1 = req_valid_i && req_ready_i;
            valid_d1  = rsp_valid_i;
        end else begin
            held      = 1'b0;
            accept_d1 = 1'b0;
            accept_d2 = 1'b0;
            valid_d1  = 1'b0;
        end
    end

endmodule

/* tests/csr_unit_tb.sv */
// Testbench of the CSR unit with a directed table, random SCRATCH traffic and back-pressure
// Build and run through the Makefile; the closing line gives the error counts

`timescale 1ns/10ps
`include "csr_unit_defines.svh"

module csr_unit_tb;

    localparam int RESET_CYCLES  = 4;
    localparam int NUM_STEPS     = 18;
    localparam int RAND_PAIRS    = 40;
    localparam int CYCLES_PER_OP = 8;
    localparam int TIMEOUT_LIMIT = RESET_CYCLES + (NUM_STEPS + 2 * RAND_PAIRS) * CYCLES_PER_OP;

    // Short aliases keep the table on one line per entry
    localparam csr_bus_pkg::csr_op_e   RD     = csr_bus_pkg::OP_READ;
    localparam csr_bus_pkg::csr_op_e   WR     = csr_bus_pkg::OP_WRITE;
    localparam csr_bus_pkg::csr_op_e   SET    = csr_bus_pkg::OP_SET;
    localparam csr_bus_pkg::csr_op_e   CLR    = csr_bus_pkg::OP_CLEAR;
    localparam csr_map_pkg::csr_addr_e A_CTRL = csr_map_pkg::ADDR_CTRL;
    localparam csr_map_pkg::csr_addr_e A_SCR  = csr_map_pkg::ADDR_SCRATCH;
    localparam csr_map_pkg::csr_addr_e A_ID   = csr_map_pkg::ADDR_ID;
    localparam csr_map_pkg::csr_addr_e A_CYC  = csr_map_pkg::ADDR_CYCLE;
    localparam logic [1:0]             K_EXACT = 2'd0;
    localparam logic [1:0]             K_ANY   = 2'd1;
    localparam logic [1:0]             K_RISE  = 2'd2;

    typedef struct packed {
        csr_bus_pkg::csr_req_t req;
        logic [`CSR_WIDTH-1:0] rdata;
        logic                  err;
        logic [1:0]            kind;
    } step_t;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid;
    logic                  req_ready;
    csr_bus_pkg::csr_req_t req;
    logic                  rsp_valid;
    logic                  rsp_ready;
    csr_bus_pkg::csr_rsp_t rsp;
    logic                  alert;
    int                    mismatch_count;
    int                    unexpected_count;
    int                    protocol_count;
    int                    pending_count;
    step_t                 step_q[$];
    string                 name_q[$];
    int                    rsp_seen;
    int                    cycle_count;

    csr_unit_top dut0 (
        .clk(clk), .rst_n(rst_n),
        .req_valid_i(req_valid), .req_ready_o(req_ready), .req_i(req),
        .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready), .rsp_o(rsp),
        .alert_o(alert)
    );

    csr_unit_checker chk0 (
        .clk(clk), .rst_n(rst_n), .req_valid_i(req_valid), .req_ready_i(req_ready),
        .rsp_valid_i(rsp_valid), .rsp_ready_i(rsp_ready), .rsp_i(rsp), .alert_i(alert),
        .mismatch_count_o(mismatch_count), .unexpected_count_o(unexpected_count),
        .protocol_count_o(protocol_count), .pending_count_o(pending_count)
    );

    bind csr_unit_top csr_unit_assertions asrt0 (
        .clk(clk), .rst_n(rst_n), .req_valid_i(req_valid_i), .req_ready_o(req_ready_o),
        .rsp_valid_o(rsp_valid_o), .rsp_ready_i(rsp_ready_i), .rsp_o(rsp_o),
        .alert_o(alert_o)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic void add_step(input string name, input csr_bus_pkg::csr_op_e op,
                                     input csr_map_pkg::csr_addr_e addr,
                                     input logic [31:0] wdata, input logic [31:0] rdata,
                                     input logic err, input logic [1:0] kind);
        step_t step;
        step.req.op    = op;
        step.req.addr  = addr;
        step.req.wdata = wdata;
        step.rdata     = rdata;
        step.err       = err;
        step.kind      = kind;
        step_q.push_back(step);
        name_q.push_back(name);
    endfunction

    task automatic load_table();
        add_step("reset_ctrl",    RD,  A_CTRL, 32'h0, `CSR_CTRL_RESET, 1'b0, K_EXACT);
        add_step("reset_scratch", RD,  A_SCR,  32'h0, `CSR_SCRATCH_RESET, 1'b0, K_EXACT);
        add_step("reset_id",      RD,  A_ID,   32'h0, `CSR_ID_VALUE, 1'b0, K_EXACT);
        add_step("reset_cycle",   RD,  A_CYC,  32'h0, 32'h0, 1'b0, K_EXACT);
        add_step("scratch_write", WR,  A_SCR,  32'hA5A5_0F0F, 32'h0, 1'b0, K_EXACT);
        add_step("scratch_set",   SET, A_SCR,  32'h0000_F0F0, 32'hA5A5_0F0F, 1'b0, K_EXACT);
        add_step("scratch_clear", CLR, A_SCR,  32'hA5A5_0000, 32'hA5A5_FFFF, 1'b0, K_EXACT);
        add_step("scratch_check", RD,  A_SCR,  32'h0, 32'h0000_FFFF, 1'b0, K_EXACT);
        // With the counter stopped the loaded value reads back unchanged
        add_step("cycle_load",    WR,  A_CYC,  32'h0000_1000, 32'h0, 1'b0, K_EXACT);
        add_step("cycle_hold",    RD,  A_CYC,  32'h0, 32'h0000_1000, 1'b0, K_EXACT);
        add_step("ctrl_write",    WR,  A_CTRL, 32'hFFFF_FFFF, 32'h0, 1'b0, K_EXACT);
        add_step("ctrl_mask",     RD,  A_CTRL, 32'h0, 32'h0000_0003, 1'b0, K_EXACT);
        add_step("cycle_first",   RD,  A_CYC,  32'h0, 32'h0, 1'b0, K_ANY);
        add_step("cycle_second",  RD,  A_CYC,  32'h0, 32'h0, 1'b0, K_RISE);
        add_step("ctrl_clear",    CLR, A_CTRL, 32'h0000_0003, 32'h0000_0003, 1'b0, K_EXACT);
        add_step("ctrl_cleared",  RD,  A_CTRL, 32'h0, 32'h0, 1'b0, K_EXACT);
        add_step("id_write",      WR,  A_ID,   32'hFFFF_FFFF, `CSR_ID_VALUE, 1'b0, K_EXACT);
        add_step("id_check",      RD,  A_ID,   32'h0, `CSR_ID_VALUE, 1'b0, K_EXACT);
    endtask

    // One complete operation with handshake, expectation, optional back-pressure and consume
    task automatic run_op(input string name, input step_t step);
        logic accepted;
        logic consumed;
        accepted  = 1'b0;
        consumed  = 1'b0;
        req       = step.req;
        req_valid = 1'b1;
        while (!accepted) begin
            accepted = req_ready;
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
        case (step.kind)
            K_ANY:   chk0.expect_any(name, step.err);
            K_RISE:  chk0.expect_rise(name, step.err);
            default: chk0.expect_exact(name, step.rdata, step.err);
        endcase
        // Every fourth response is held for 3 cycles
        if (rsp_seen % 4 == 3) begin
            rsp_ready = 1'b0;
            while (!rsp_valid) begin
                @(posedge clk);
                #1;
            end
            repeat (3) begin
                @(posedge clk);
                #1;
            end
            rsp_ready = 1'b1;
        end
        while (!consumed) begin
            consumed = rsp_valid && rsp_ready;
            @(posedge clk);
            #1;
        end
        rsp_seen++;
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("ERROR: run did not finish within %0d cycles", TIMEOUT_LIMIT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        logic [31:0] rand_state;
        logic [31:0] scratch_model;
        step_t       step;
        int          total;
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b1;
        rsp_seen  = 0;
        load_table();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        foreach (step_q[i]) begin
            run_op(name_q[i], step_q[i]);
        end

        // Random WRITE then READ pairs start from the value the table left
        rand_state    = 32'h64be;
        scratch_model = 32'h0000_FFFF;
        for (int i = 0; i < RAND_PAIRS; i++) begin
            rand_state = xorshift32(rand_state);
            step       = '{req: '{op: WR, addr: A_SCR, wdata: rand_state},
                           rdata: scratch_model, err: 1'b0, kind: K_EXACT};
            run_op($sformatf("rand_write_%0d", i), step);
            scratch_model = (rand_state & `CSR_SCRATCH_MASK) |
                            (`CSR_SCRATCH_RESET & ~`CSR_SCRATCH_MASK);
            step.req.op   = RD;
            step.rdata    = scratch_model;
            run_op($sformatf("rand_read_%0d", i), step);
        end

        repeat (2) @(posedge clk);
        total = mismatch_count + unexpected_count + protocol_count + pending_count;
        $display("Errors: %0d mismatched, %0d unexpected, %0d protocol, %0d missing responses",
                 mismatch_count, unexpected_count, protocol_count, pending_count);
        if (total == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* csr_unit.f */
+incdir+include
rtl/csr_map_pkg.sv
rtl/csr_bus_pkg.sv
rtl/csr_reg.sv
rtl/csr_cycle_counter.sv
rtl/csr_access_fsm.sv
rtl/csr_file.sv
rtl/csr_unit_top.sv
tests/csr_unit_assertions.sv
tests/csr_unit_checker.sv
tests/csr_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := csr_unit_tb
FILELIST  := csr_unit.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard include/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
